// File: design/ipv4_tx_pkg.sv
package ipv4_tx_pkg;

  typedef logic [31:0] ipv4_addr_t;
  typedef logic [47:0] mac_addr_t;
  typedef logic [15:0] len_t;
  typedef logic [7:0]  byte_t;

  localparam int    IPV4_HDR_LEN   = 20;
  localparam byte_t IPV4_VER_IHL   = 8'h45; // Version 4, five words.
  localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
  localparam int    CKS_LAT        = 3;
  localparam int    ARP_ENTRIES    = 4;
  localparam int    PLD_DEPTH      = 2048;

  // One entry per datagram from the client.
  typedef struct packed {
    ipv4_addr_t  dst_ip;
    logic [15:0] id;
    logic [7:0]  ttl;
    logic [7:0]  proto;
    logic        df;
    len_t        pld_len;
    mac_addr_t   dst_mac;
    logic        mac_known; // Low means look up dst_ip in the ARP cache.
  } ipv4_meta_t;

  typedef struct packed {
    ipv4_addr_t src_ip;
    mac_addr_t  src_mac;
  } dev_t;

  typedef struct packed {
    mac_addr_t   dst_mac;
    mac_addr_t   src_mac;
    logic [15:0] ethertype;
  } eth_hdr_t;

  typedef struct packed {
    byte_t dat;
    logic  val;
    logic  sof;
    logic  eof;
  } mac_strm_t;

  typedef enum logic [2:0] {
    idle_s,
    arp_s,
    drain_s,
    prep_s,
    stream_s
  } tx_state_t;

endpackage

// File: design/ipv4_hdr_checksum.sv
`timescale 1ns/1ps

module ipv4_hdr_checksum (
  input  logic                                           clk,
  input  logic                                           fsm_rst,
  input  ipv4_tx_pkg::byte_t [ipv4_tx_pkg::IPV4_HDR_LEN-1:0] hdr,
  output logic [15:0]                                    cks
);

  logic [4:0][16:0] sum_s1; // Pairs of header words.
  logic [2:0][17:0] sum_s2;
  logic [19:0]      sum_s3;
  logic [16:0]      fold;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      sum_s1 <= '0;
      sum_s2 <= '0;
      sum_s3 <= '0;
    end else begin
      for (int i = 0; i < 5; i++) begin
        sum_s1[i] <= {1'b0, hdr[4*i+3], hdr[4*i+2]} + {1'b0, hdr[4*i+1], hdr[4*i]};
      end
      sum_s2[0] <= {1'b0, sum_s1[0]} + {1'b0, sum_s1[1]};
      sum_s2[1] <= {1'b0, sum_s1[2]} + {1'b0, sum_s1[3]};
      sum_s2[2] <= {1'b0, sum_s1[4]}; // Odd word out waits a stage.
      sum_s3    <= {2'b00, sum_s2[0]} + {2'b00, sum_s2[1]} + {2'b00, sum_s2[2]};
    end
  end

  // End-around carry, folded twice since the first fold can carry again.
  assign fold = {1'b0, sum_s3[15:0]} + {13'b0, sum_s3[19:16]};
  assign cks  = ~(fold[15:0] + {15'b0, fold[16]});

endmodule

// File: design/arp_cache.sv
`timescale 1ns/1ps

module arp_cache (
  input  logic                   clk,
  input  logic                   fsm_rst,
  input  logic                   arp_wr,
  input  ipv4_tx_pkg::ipv4_addr_t arp_wr_ip,
  input  ipv4_tx_pkg::mac_addr_t  arp_wr_mac,
  input  logic                   arp_req,
  input  ipv4_tx_pkg::ipv4_addr_t arp_ip,
  output logic                   arp_hit,
  output logic                   arp_miss,
  output ipv4_tx_pkg::mac_addr_t  arp_mac
);

  import ipv4_tx_pkg::*;

  logic       [ARP_ENTRIES-1:0]         vld;
  ipv4_addr_t                           ip_tbl  [ARP_ENTRIES];
  mac_addr_t                            mac_tbl [ARP_ENTRIES];
  logic       [$clog2(ARP_ENTRIES)-1:0] rr;     // Next entry to replace.
  logic       [$clog2(ARP_ENTRIES)-1:0] wr_idx;
  logic       [$clog2(ARP_ENTRIES)-1:0] lk_idx;
  logic                                 wr_hit;
  logic                                 lk_hit;
  logic                                 req_q;
  logic                                 lk_new;

  always_comb begin
    wr_hit = 1'b0;
    wr_idx = rr;
    lk_hit = 1'b0;
    lk_idx = '0;
    for (int i = 0; i < ARP_ENTRIES; i++) begin
      if (vld[i] && ip_tbl[i] == arp_wr_ip) begin
        wr_hit = 1'b1;
        wr_idx = i[$clog2(ARP_ENTRIES)-1:0];
      end
      if (vld[i] && ip_tbl[i] == arp_ip) begin
        lk_hit = 1'b1;
        lk_idx = i[$clog2(ARP_ENTRIES)-1:0];
      end
    end
  end

  assign lk_new = arp_req && !req_q; // One answer per request.

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      vld      <= '0;
      rr       <= '0;
      req_q    <= 1'b0;
      arp_hit  <= 1'b0;
      arp_miss <= 1'b0;
    end else begin
      req_q    <= arp_req;
      arp_hit  <= lk_new && lk_hit;
      arp_miss <= lk_new && !lk_hit;
      if (arp_wr) begin
        vld[wr_idx] <= 1'b1;
        if (!wr_hit) rr <= rr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (arp_wr) begin
      ip_tbl[wr_idx]  <= arp_wr_ip;
      mac_tbl[wr_idx] <= arp_wr_mac;
    end
    if (lk_new && lk_hit) arp_mac <= mac_tbl[lk_idx];
  end

endmodule

// File: design/payload_fifo.sv
`timescale 1ns/1ps

module payload_fifo (
  input  logic               clk,
  input  logic               fsm_rst,
  input  logic               pld_wr,
  input  ipv4_tx_pkg::byte_t pld_dat,
  input  logic               pld_rd,
  output ipv4_tx_pkg::byte_t pld_q,
  output logic               pld_full
);

  import ipv4_tx_pkg::*;

  byte_t                      mem [PLD_DEPTH];
  logic [$clog2(PLD_DEPTH):0] wr_ptr; // Top bit tells full from empty.
  logic [$clog2(PLD_DEPTH):0] rd_ptr;
  logic                       empty;

  assign empty    = (wr_ptr == rd_ptr);
  assign pld_full = (wr_ptr[$clog2(PLD_DEPTH)] != rd_ptr[$clog2(PLD_DEPTH)]) &&
                    (wr_ptr[$clog2(PLD_DEPTH)-1:0] == rd_ptr[$clog2(PLD_DEPTH)-1:0]);

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (pld_wr && !pld_full) wr_ptr <= wr_ptr + 1'b1;
      if (pld_rd && !empty)    rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (pld_wr && !pld_full) mem[wr_ptr[$clog2(PLD_DEPTH)-1:0]] <= pld_dat;
    if (pld_rd && !empty)    pld_q <= mem[rd_ptr[$clog2(PLD_DEPTH)-1:0]];
  end

endmodule

// File: design/ipv4_tx_framer.sv
`timescale 1ns/1ps

module ipv4_tx_framer (
  input  logic                    clk,
  input  logic                    fsm_rst,
  input  ipv4_tx_pkg::dev_t       dev,
  input  logic                    meta_val,
  input  ipv4_tx_pkg::ipv4_meta_t meta,
  output logic                    meta_acc,
  output logic                    done,
  output logic                    err,
  output logic                    arp_req,
  output ipv4_tx_pkg::ipv4_addr_t arp_ip,
  input  logic                    arp_hit,
  input  logic                    arp_miss,
  input  ipv4_tx_pkg::mac_addr_t  arp_mac,
  output ipv4_tx_pkg::byte_t [ipv4_tx_pkg::IPV4_HDR_LEN-1:0] hdr,
  input  logic [15:0]             cks,
  output logic                    pld_rd,
  input  ipv4_tx_pkg::byte_t      pld_q,
  output logic                    mac_rdy,
  input  logic                    mac_req,
  output ipv4_tx_pkg::eth_hdr_t   eth_hdr,
  output ipv4_tx_pkg::mac_strm_t  strm
);

  import ipv4_tx_pkg::*;

  tx_state_t  state;
  ipv4_meta_t meta_q;
  len_t       tot_len; // Header plus payload, in beats.
  len_t       acc_len;
  len_t       cnt;

  assign acc_len = meta.pld_len + len_t'(IPV4_HDR_LEN);
  assign arp_ip  = meta_q.dst_ip;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state    <= idle_s;
      cnt      <= '0;
      meta_acc <= 1'b0;
      done     <= 1'b0;
      err      <= 1'b0;
      arp_req  <= 1'b0;
      pld_rd   <= 1'b0;
      mac_rdy  <= 1'b0;
      strm     <= '0;
    end else begin
      meta_acc <= 1'b0;
      done     <= 1'b0;
      case (state)
        idle_s: begin
          cnt <= '0;
          if (meta_val) begin
            meta_acc <= 1'b1;
            arp_req  <= !meta.mac_known;
            state    <= meta.mac_known ? prep_s : arp_s;
          end
        end
        arp_s: begin
          if (arp_hit || arp_miss) arp_req <= 1'b0;
          if (arp_hit)  state <= prep_s;
          if (arp_miss) state <= drain_s; // Drop, but keep the FIFO aligned.
        end
        drain_s: begin
          if (cnt == meta_q.pld_len) begin
            pld_rd <= 1'b0;
            done   <= 1'b1;
            err    <= 1'b1;
            state  <= idle_s;
          end else begin
            pld_rd <= 1'b1;
            cnt    <= cnt + 16'd1;
          end
        end
        prep_s: begin
          if (cnt != len_t'(CKS_LAT)) begin
            cnt <= cnt + 16'd1;
          end else if (!mac_rdy) begin
            mac_rdy <= 1'b1;
          end else if (mac_req) begin
            mac_rdy <= 1'b0;
            strm    <= '{dat: hdr[IPV4_HDR_LEN-1], val: 1'b1, sof: 1'b1, eof: 1'b0};
            cnt     <= 16'd1;
            state   <= stream_s;
          end
        end
        stream_s: begin
          if (cnt == tot_len) begin
            strm  <= '0;
            done  <= 1'b1;
            err   <= 1'b0;
            state <= idle_s;
          end else begin
            strm.dat <= (cnt < len_t'(IPV4_HDR_LEN)) ? hdr[IPV4_HDR_LEN-1] : pld_q;
            strm.val <= 1'b1;
            strm.sof <= 1'b0;
            strm.eof <= (cnt == tot_len - 16'd1);
            // FIFO output is registered, so read two beats ahead.
            pld_rd   <= (cnt >= len_t'(IPV4_HDR_LEN - 2)) && (cnt < tot_len - 16'd2);
            cnt      <= cnt + 16'd1;
          end
        end
        default: state <= idle_s;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      idle_s: begin
        if (meta_val) begin
          meta_q     <= meta;
          tot_len    <= acc_len;
          eth_hdr    <= '{dst_mac: meta.dst_mac, src_mac: dev.src_mac,
                          ethertype: ETHERTYPE_IPV4};
          hdr[19]    <= IPV4_VER_IHL;
          hdr[18]    <= 8'h00;             // TOS.
          hdr[17:16] <= acc_len;
          hdr[15:14] <= meta.id;
          hdr[13]    <= {1'b0, meta.df, 6'b0};
          hdr[12]    <= 8'h00;
          hdr[11]    <= meta.ttl;
          hdr[10]    <= meta.proto;
          hdr[9:8]   <= 16'h0000;          // Filled in from cks in prep.
          hdr[7:4]   <= dev.src_ip;
          hdr[3:0]   <= meta.dst_ip;
        end
      end
      arp_s: if (arp_hit) eth_hdr.dst_mac <= arp_mac;
      prep_s: begin
        if (cnt == len_t'(CKS_LAT) && !mac_rdy) begin
          hdr[9:8] <= cks;
        end else if (mac_rdy && mac_req) begin
          hdr <= {hdr[IPV4_HDR_LEN-2:0], 8'h00};
        end
      end
      stream_s: if (cnt != tot_len) hdr <= {hdr[IPV4_HDR_LEN-2:0], 8'h00};
      default: ;
    endcase
  end

endmodule

// File: design/ipv4_tx_top.sv
`timescale 1ns/1ps

module ipv4_tx_top (
  input  logic                    clk,
  input  logic                    fsm_rst,
  input  ipv4_tx_pkg::dev_t       dev,
  input  logic                    meta_val,
  input  ipv4_tx_pkg::ipv4_meta_t meta,
  output logic                    meta_acc,
  input  logic                    pld_wr,
  input  ipv4_tx_pkg::byte_t      pld_dat,
  output logic                    pld_full,
  input  logic                    arp_wr,
  input  ipv4_tx_pkg::ipv4_addr_t arp_wr_ip,
  input  ipv4_tx_pkg::mac_addr_t  arp_wr_mac,
  output logic                    mac_rdy,
  input  logic                    mac_req,
  output ipv4_tx_pkg::eth_hdr_t   eth_hdr,
  output ipv4_tx_pkg::mac_strm_t  strm,
  output logic                    done,
  output logic                    err
);

  import ipv4_tx_pkg::*;

  byte_t [IPV4_HDR_LEN-1:0] hdr; // Header with the checksum field zero.
  logic  [15:0]             cks;
  logic                     arp_req;
  ipv4_addr_t               arp_ip;
  logic                     arp_hit;
  logic                     arp_miss;
  mac_addr_t                arp_mac;
  logic                     pld_rd;
  byte_t                    pld_q;

  ipv4_tx_framer ipv4_tx_framer_inst (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .dev      (dev),
    .meta_val (meta_val),
    .meta     (meta),
    .meta_acc (meta_acc),
    .done     (done),
    .err      (err),
    .arp_req  (arp_req),
    .arp_ip   (arp_ip),
    .arp_hit  (arp_hit),
    .arp_miss (arp_miss),
    .arp_mac  (arp_mac),
    .hdr      (hdr),
    .cks      (cks),
    .pld_rd   (pld_rd),
    .pld_q    (pld_q),
    .mac_rdy  (mac_rdy),
    .mac_req  (mac_req),
    .eth_hdr  (eth_hdr),
    .strm     (strm)
  );

  ipv4_hdr_checksum ipv4_hdr_checksum_inst (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .hdr     (hdr),
    .cks     (cks)
  );

  arp_cache arp_cache_inst (
    .clk        (clk),
    .fsm_rst    (fsm_rst),
    .arp_wr     (arp_wr),
    .arp_wr_ip  (arp_wr_ip),
    .arp_wr_mac (arp_wr_mac),
    .arp_req    (arp_req),
    .arp_ip     (arp_ip),
    .arp_hit    (arp_hit),
    .arp_miss   (arp_miss),
    .arp_mac    (arp_mac)
  );

  payload_fifo payload_fifo_inst (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .pld_wr   (pld_wr),
    .pld_dat  (pld_dat),
    .pld_rd   (pld_rd),
    .pld_q    (pld_q),
    .pld_full (pld_full)
  );

endmodule

// File: testbench/ipv4_tx_sva.sv
`timescale 1ns/1ps

module ipv4_tx_sva (
  input logic                   clk,
  input logic                   fsm_rst,
  input logic                   mac_rdy,
  input logic                   mac_req,
  input ipv4_tx_pkg::mac_strm_t strm,
  input logic                   done
);

  // No gaps between sof and eof.
  property val_through_frame;
    @(posedge clk) disable iff (fsm_rst)
      (strm.val && !strm.eof) |=> strm.val;
  endproperty

  property rdy_drops_after_req;
    @(posedge clk) disable iff (fsm_rst)
      mac_req |=> !mac_rdy;
  endproperty

  property done_one_cycle;
    @(posedge clk) disable iff (fsm_rst)
      done |=> !done;
  endproperty

  val_through_frame_a: assert property (val_through_frame)
    else $error("strm.val dropped inside a frame");
  rdy_drops_after_req_a: assert property (rdy_drops_after_req)
    else $error("mac_rdy still high the cycle after mac_req");
  done_one_cycle_a: assert property (done_one_cycle)
    else $error("done held for more than one cycle");

endmodule

// File: testbench/ipv4_tx_tb.sv
`timescale 1ns/1ps

module ipv4_tx_tb;

  import ipv4_tx_pkg::*;

  typedef byte_t byte_q_t[$];

  localparam int NUM_FRAMES = 23; // Three directed frames, twenty random ones.

  logic       clk;
  logic       fsm_rst;
  dev_t       dev;
  logic       meta_val;
  ipv4_meta_t meta;
  logic       meta_acc;
  logic       pld_wr;
  byte_t      pld_dat;
  logic       pld_full;
  logic       arp_wr;
  ipv4_addr_t arp_wr_ip;
  mac_addr_t  arp_wr_mac;
  logic       mac_rdy;
  logic       mac_req;
  eth_hdr_t   eth_hdr;
  mac_strm_t  strm;
  logic       done;
  logic       err;

  integer     seed = 32'hdeb2_9cc8;
  byte_t      exp_bytes[$];
  int         exp_len[$];
  logic       exp_err[$];
  eth_hdr_t   exp_eth[$];
  byte_q_t    last_pld;
  ipv4_meta_t frames[NUM_FRAMES];
  ipv4_addr_t cached_ip[3];
  mac_addr_t  cached_mac[3];
  int         beats = 0;
  int         wd_cycles = 0;

  ipv4_tx_top ipv4_tx_top_inst (.*);

  bind ipv4_tx_top ipv4_tx_sva ipv4_tx_sva_inst (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .mac_rdy (mac_rdy),
    .mac_req (mac_req),
    .strm    (strm),
    .done    (done)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Header bytes with the checksum worked out from RFC 791, then the payload.
  function automatic byte_q_t expected_frame(ipv4_meta_t m, ipv4_addr_t src_ip, byte_q_t pld);
    logic [159:0] h;
    logic [31:0]  sum;
    len_t         tot;
    byte_q_t      q;
    tot = m.pld_len + 16'd20;
    h = {8'h45, 8'h00, tot, m.id, 1'b0, m.df, 14'h0, m.ttl, m.proto, 16'h0, src_ip, m.dst_ip};
    sum = 32'h0;
    for (int i = 0; i < 10; i++) sum = sum + {16'h0, h[159-16*i -: 16]};
    while (sum[31:16] != 16'h0) sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
    h[79:64] = ~sum[15:0];
    for (int i = 0; i < 20; i++) q.push_back(h[159-8*i -: 8]);
    foreach (pld[i]) q.push_back(pld[i]);
    return q;
  endfunction

  function automatic eth_hdr_t expected_eth(mac_addr_t dst, mac_addr_t src);
    return '{dst_mac: dst, src_mac: src, ethertype: 16'h0800};
  endfunction

  function automatic int rand_below(int n);
    logic [31:0] r;
    r = $random(seed);
    return int'(r[30:0]) % n;
  endfunction

  function automatic mac_addr_t random_mac();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = $random(seed);
    lo = $random(seed);
    return {hi[15:0], lo};
  endfunction

  function automatic ipv4_meta_t random_meta(int len, logic known, ipv4_addr_t ip);
    ipv4_meta_t m;
    m.dst_ip    = ip;
    m.id        = 16'($random(seed));
    m.ttl       = 8'($random(seed));
    m.proto     = 8'($random(seed));
    m.df        = 1'($random(seed));
    m.pld_len   = len_t'(len);
    m.dst_mac   = random_mac();
    m.mac_known = known;
    return m;
  endfunction

  task automatic stop_run();
    $display("Errors found");
    $fatal(1, "Run stopped.");
  endtask

  task automatic check_value(string what, logic [127:0] got, logic [127:0] exp);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic write_arp(int idx, ipv4_addr_t ip, mac_addr_t mac);
    @(posedge clk);
    arp_wr     <= 1'b1;
    arp_wr_ip  <= ip;
    arp_wr_mac <= mac;
    @(posedge clk);
    arp_wr <= 1'b0;
    cached_ip[idx]  = ip;
    cached_mac[idx] = mac;
  endtask

  task automatic send_frame(ipv4_meta_t m, logic reuse);
    byte_q_t   pld;
    byte_q_t   exp;
    mac_addr_t dst;
    logic      miss;
    dst  = m.dst_mac;
    miss = !m.mac_known;
    if (!m.mac_known) begin
      for (int j = 0; j < 3; j++) begin
        if (cached_ip[j] == m.dst_ip) begin
          dst  = cached_mac[j];
          miss = 1'b0;
        end
      end
    end
    if (reuse) begin
      pld = last_pld;
    end else begin
      for (int i = 0; i < int'(m.pld_len); i++) pld.push_back(byte_t'($random(seed)));
    end
    last_pld = pld;
    exp = expected_frame(m, dev.src_ip, pld);
    exp_err.push_back(miss);
    exp_eth.push_back(expected_eth(dst, dev.src_mac));
    exp_len.push_back(miss ? 0 : exp.size());
    if (!miss) begin
      foreach (exp[i]) exp_bytes.push_back(exp[i]);
    end
    foreach (pld[i]) begin
      @(posedge clk);
      pld_wr  <= 1'b1;
      pld_dat <= pld[i];
    end
    @(posedge clk);
    pld_wr   <= 1'b0;
    meta_val <= 1'b1;
    meta     <= m;
    @(posedge clk);
    meta_val <= 1'b0;
    @(negedge clk);
    check_value("meta_acc", 128'(meta_acc), 128'(1'b1));
    // A few dozen bytes never fill the FIFO.
    check_value("pld_full", 128'(pld_full), 128'(1'b0));
    while (!done) @(negedge clk);
  endtask

  // MAC side. Answers mac_rdy after a short random wait.
  initial begin
    int hold;
    mac_req = 1'b0;
    forever begin
      @(negedge clk);
      if (mac_rdy && !mac_req) begin
        hold = rand_below(4);
        repeat (hold) @(posedge clk);
        @(posedge clk);
        mac_req <= 1'b1;
        @(posedge clk);
        mac_req <= 1'b0;
      end
    end
  end

  always @(negedge clk) begin
    if (!fsm_rst && strm.val) begin
      if (exp_bytes.size() == 0 || exp_len.size() == 0) begin
        $display("A stream beat came out at %0t ns with no frame expected", $time);
        stop_run();
      end else begin
        check_value("strm.dat", 128'(strm.dat), 128'(exp_bytes.pop_front()));
        check_value("strm.sof", 128'(strm.sof), 128'(beats == 0));
        check_value("strm.eof", 128'(strm.eof), 128'(beats == exp_len[0] - 1));
        if (strm.sof) check_value("eth_hdr", 128'(eth_hdr), 128'(exp_eth[0]));
        beats = beats + 1;
      end
    end
    if (!fsm_rst && done) begin
      if (exp_err.size() == 0) begin
        $display("done pulsed at %0t ns with no datagram outstanding", $time);
        stop_run();
      end else begin
        check_value("err", 128'(err), 128'(exp_err.pop_front()));
        check_value("beat count", 128'(beats), 128'(exp_len.pop_front()));
        void'(exp_eth.pop_front());
        beats = 0;
      end
    end
  end

  initial begin
    wait (wd_cycles > 0);
    repeat (wd_cycles) @(posedge clk);
    $display("Timeout: the test did not finish within %0d cycles", wd_cycles);
    stop_run();
  end

  initial begin
    logic       known;
    ipv4_addr_t ip;
    int         len;
    int         limit;
    fsm_rst    = 1'b1;
    meta_val   = 1'b0;
    meta       = '0;
    pld_wr     = 1'b0;
    pld_dat    = '0;
    arp_wr     = 1'b0;
    arp_wr_ip  = '0;
    arp_wr_mac = '0;
    dev        = '{src_ip: {8'd192, 8'd168, 16'($random(seed))}, src_mac: random_mac()};
    for (int i = 0; i < 3; i++) begin
      cached_ip[i]  = {8'd10, 8'(i), 16'($random(seed))};
      cached_mac[i] = random_mac();
    end
    frames[0] = random_meta(12, 1'b1, cached_ip[0]);
    frames[1] = frames[0];
    frames[1].mac_known = 1'b0; // Same datagram with the MAC taken from the cache.
    frames[2] = random_meta(30, 1'b0, {8'd10, 8'd9, 16'($random(seed))});
    for (int k = 3; k < NUM_FRAMES; k++) begin
      known = (rand_below(2) == 1);
      ip    = known ? ipv4_addr_t'($random(seed)) : cached_ip[rand_below(3)];
      len   = (k == 3) ? 0 : (k == 4) ? 1 : rand_below(48);
      if (k == 14) begin
        known = 1'b0;
        ip    = cached_ip[1];
      end
      frames[k] = random_meta(len, known, ip);
    end
    // Second length term covers the payload writes.
    limit = 300;
    foreach (frames[k]) limit += (int'(frames[k].pld_len) + 40) + int'(frames[k].pld_len);
    wd_cycles = limit;

    repeat (16) @(posedge clk);
    fsm_rst <= 1'b0;
    @(negedge clk);
    check_value("mac_rdy after reset", 128'(mac_rdy), 128'(1'b0));
    check_value("strm.val after reset", 128'(strm.val), 128'(1'b0));
    check_value("meta_acc after reset", 128'(meta_acc), 128'(1'b0));
    check_value("done after reset", 128'(done), 128'(1'b0));
    for (int i = 0; i < 3; i++) write_arp(i, cached_ip[i], cached_mac[i]);

    for (int k = 0; k < NUM_FRAMES; k++) begin
      if (k == 14) write_arp(1, cached_ip[1], random_mac()); // New MAC for a known IP.
      send_frame(frames[k], k == 1);
    end
    repeat (4) @(posedge clk);
    $display("No errors");
    $finish;
  end

endmodule

// File: ipv4_tx.f
design/ipv4_tx_pkg.sv
design/ipv4_hdr_checksum.sv
design/arp_cache.sv
design/payload_fifo.sv
design/ipv4_tx_framer.sv
design/ipv4_tx_top.sv
testbench/ipv4_tx_sva.sv
testbench/ipv4_tx_tb.sv

// File: run.sh
#!/bin/sh
# Compile and run the IPv4 transmit testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module ipv4_tx_tb -f ipv4_tx.f -Mdir obj_dir -o ipv4_tx_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/ipv4_tx_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit "$status"
fi
exit 0
